// ==== rv32i_types_pkg.sv ====
//////////////////////////////
// RV32I base ISA only: no compressed encodings
// opcode values are the full 7-bit field, low bits 2'b11
// x0 is index 0 and is never a real dependency
//////////////////////////////
`default_nettype none

package rv32i_types_pkg;

    // instruction words and addresses share one width
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcode, instr[6:0]
    typedef logic [6:0] opcode_t;

    // minor opcode, instr[14:12]
    typedef logic [2:0] funct3_t;

    // size of the integer register file
    localparam int NUM_REGS = 32;

    // major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    // csr access, ecall and ebreak
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // FENCE and anything else decodes as illegal

endpackage

`default_nettype wire

// ==== uop_types_pkg.sv ====
//////////////////////////////
// one micro-op per instruction, no cracking
// QUEUE_LEN must be a power of two, pointers wrap by overflow
// entry packing order: pc, fu, rd, rs1, rs2,
// uses_rs1, uses_rs2, writes_rd, imm, funct3 (msb first)
//////////////////////////////
`default_nettype none

package uop_types_pkg;

    // target functional unit
    localparam int FU_WIDTH = 3;

    typedef enum logic [FU_WIDTH-1:0] {
        FU_ALU     = 3'd0,
        FU_BRANCH  = 3'd1,
        FU_LSU     = 3'd2,
        FU_SYS     = 3'd3,
        FU_ILLEGAL = 3'd4
    } fu_t;

    // immediate, already sign extended
    typedef logic [31:0] imm_t;

    // decode queue depth
    localparam int QUEUE_LEN = 8;
    localparam int QPTR_W    = $clog2(QUEUE_LEN);

    typedef logic [QPTR_W-1:0] qptr_t;
    // one extra bit so a full queue is representable
    typedef logic [QPTR_W:0] qcount_t;

    // scoreboard, one busy bit per architectural register
    typedef logic [rv32i_types_pkg::NUM_REGS-1:0] busy_vec_t;

    // width of one packed queue entry
    localparam int UOP_WIDTH = $bits(rv32i_types_pkg::word_t)
                             + FU_WIDTH
                             + 3 * $bits(rv32i_types_pkg::reg_idx_t)
                             + 3
                             + $bits(imm_t)
                             + $bits(rv32i_types_pkg::funct3_t);

    typedef logic [UOP_WIDTH-1:0] uop_entry_t;

endpackage

`default_nettype wire

// ==== uop_decoder.sv ====
//////////////////////////////
// one instruction per transfer, result registered
// use and write flags come from the opcode alone
// unknown opcodes give FU_ILLEGAL with all flags clear
// flush drops the registered micro-op
//////////////////////////////
`default_nettype none

module uop_decoder (
    input  wire                          CLK,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          fetch_valid,
    input  wire rv32i_types_pkg::word_t  instr,
    input  wire rv32i_types_pkg::word_t  pc,
    input  wire                          dec_ready,
    output logic                         fetch_ready,
    output logic                         dec_valid,
    output rv32i_types_pkg::word_t       dec_pc,
    output uop_types_pkg::fu_t           dec_fu,
    output rv32i_types_pkg::reg_idx_t    dec_rd,
    output rv32i_types_pkg::reg_idx_t    dec_rs1,
    output rv32i_types_pkg::reg_idx_t    dec_rs2,
    output logic                         dec_uses_rs1,
    output logic                         dec_uses_rs2,
    output logic                         dec_writes_rd,
    output uop_types_pkg::imm_t          dec_imm,
    output rv32i_types_pkg::funct3_t     dec_funct3
);

    rv32i_types_pkg::opcode_t opcode;
    uop_types_pkg::imm_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    uop_types_pkg::fu_t       d_fu;
    uop_types_pkg::imm_t      d_imm;
    logic                     d_uses_rs1, d_uses_rs2, d_writes_rd;
    logic                     load;

    assign opcode = instr[6:0];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // default covers unknown opcodes
        d_fu        = uop_types_pkg::FU_ILLEGAL;
        d_imm       = '0;
        d_uses_rs1  = 1'b0;
        d_uses_rs2  = 1'b0;
        d_writes_rd = 1'b0;
        case (opcode)
            rv32i_types_pkg::OPC_LUI, rv32i_types_pkg::OPC_AUIPC: begin
                d_fu        = uop_types_pkg::FU_ALU;
                d_imm       = imm_u;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_JAL: begin
                d_fu        = uop_types_pkg::FU_BRANCH;
                d_imm       = imm_j;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_JALR: begin
                d_fu        = uop_types_pkg::FU_BRANCH;
                d_imm       = imm_i;
                d_uses_rs1  = 1'b1;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_BRANCH: begin
                d_fu       = uop_types_pkg::FU_BRANCH;
                d_imm      = imm_b;
                d_uses_rs1 = 1'b1;
                d_uses_rs2 = 1'b1;
            end
            rv32i_types_pkg::OPC_LOAD: begin
                d_fu        = uop_types_pkg::FU_LSU;
                d_imm       = imm_i;
                d_uses_rs1  = 1'b1;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_STORE: begin
                d_fu       = uop_types_pkg::FU_LSU;
                d_imm      = imm_s;
                d_uses_rs1 = 1'b1;
                d_uses_rs2 = 1'b1;
            end
            rv32i_types_pkg::OPC_OPIMM: begin
                d_fu        = uop_types_pkg::FU_ALU;
                d_imm       = imm_i;
                d_uses_rs1  = 1'b1;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_OP: begin
                // register-register, no immediate
                d_fu        = uop_types_pkg::FU_ALU;
                d_uses_rs1  = 1'b1;
                d_uses_rs2  = 1'b1;
                d_writes_rd = 1'b1;
            end
            rv32i_types_pkg::OPC_SYSTEM: begin
                // treated as csr access: reads rs1, writes rd
                d_fu        = uop_types_pkg::FU_SYS;
                d_imm       = imm_i;
                d_uses_rs1  = 1'b1;
                d_writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

    // take a new word when the register is empty or draining
    assign fetch_ready = !flush && (!dec_valid || dec_ready);
    assign load        = fetch_valid && fetch_ready;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // payload, no reset
    always_ff @(posedge CLK) begin
        if (load) begin
            dec_pc        <= pc;
            dec_fu        <= d_fu;
            dec_rd        <= instr[11:7];
            dec_rs1       <= instr[19:15];
            dec_rs2       <= instr[24:20];
            dec_uses_rs1  <= d_uses_rs1;
            dec_uses_rs2  <= d_uses_rs2;
            dec_writes_rd <= d_writes_rd;
            dec_imm       <= d_imm;
            dec_funct3    <= instr[14:12];
        end
    end

endmodule

`default_nettype wire

// ==== decode_queue.sv ====
//////////////////////////////
// circular FIFO, QUEUE_LEN entries
// head entry is read combinationally
// push and pop allowed together, also when full
// flush empties it, nothing enters that cycle
//////////////////////////////
`default_nettype none

module decode_queue (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             flush,
    input  wire                             in_valid,
    input  wire uop_types_pkg::uop_entry_t  in_entry,
    input  wire                             out_ready,
    output logic                            in_ready,
    output logic                            out_valid,
    output uop_types_pkg::uop_entry_t       out_entry,
    output uop_types_pkg::qcount_t          free_slots
);

    // storage, no reset
    uop_types_pkg::uop_entry_t mem [uop_types_pkg::QUEUE_LEN];

    uop_types_pkg::qptr_t   head;
    uop_types_pkg::qptr_t   tail;
    uop_types_pkg::qcount_t count;
    logic                   push;
    logic                   pop;

    assign out_valid  = (count != '0);
    assign out_entry  = mem[head];
    assign free_slots = uop_types_pkg::qcount_t'(uop_types_pkg::QUEUE_LEN) - count;

    assign pop = out_valid && out_ready;
    // a pop frees a slot in the same cycle
    assign in_ready = !flush && ((free_slots != '0) || pop);
    assign push     = in_valid && in_ready;

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[tail] <= in_entry;
        end
    end

    // pointers wrap by overflow
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // both or neither, occupancy unchanged
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uop_issue.sv ====
//////////////////////////////
// in-order issue, one register toward execute
// single busy bit per register, x0 never busy
// set on acceptance beats a writeback clear
// flush keeps the scoreboard, only a squashed
// un-issued entry gives its busy bit back
//////////////////////////////
`default_nettype none

module uop_issue (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             flush,
    input  wire                             q_valid,
    input  wire uop_types_pkg::uop_entry_t  q_entry,
    input  wire                             uop_ready,
    input  wire                             wb_valid,
    input  wire rv32i_types_pkg::reg_idx_t  wb_rd,
    output logic                            q_ready,
    output logic                            uop_valid,
    output rv32i_types_pkg::word_t          uop_pc,
    output uop_types_pkg::fu_t              uop_fu,
    output rv32i_types_pkg::reg_idx_t       uop_rd,
    output rv32i_types_pkg::reg_idx_t       uop_rs1,
    output rv32i_types_pkg::reg_idx_t       uop_rs2,
    output uop_types_pkg::imm_t             uop_imm,
    output rv32i_types_pkg::funct3_t        uop_funct3,
    output logic                            uop_writes_rd
);

    // head entry fields
    rv32i_types_pkg::word_t    h_pc;
    logic [uop_types_pkg::FU_WIDTH-1:0] h_fu;
    rv32i_types_pkg::reg_idx_t h_rd, h_rs1, h_rs2;
    logic                      h_uses_rs1, h_uses_rs2, h_writes_rd;
    uop_types_pkg::imm_t       h_imm;
    rv32i_types_pkg::funct3_t  h_funct3;

    uop_types_pkg::busy_vec_t  busy;
    logic                      hazard;
    logic                      slot_free;
    logic                      take;
    logic                      squash;

    assign {h_pc, h_fu, h_rd, h_rs1, h_rs2, h_uses_rs1, h_uses_rs2, h_writes_rd,
            h_imm, h_funct3} = q_entry;

    // RAW check against outstanding writers
    assign hazard = (h_uses_rs1 && (h_rs1 != '0) && busy[h_rs1])
                 || (h_uses_rs2 && (h_rs2 != '0) && busy[h_rs2]);

    assign slot_free = !uop_valid || uop_ready;
    assign q_ready   = !flush && slot_free && !hazard;
    assign take      = q_valid && q_ready;

    // entry dropped by flush before execute took it, never writes back
    assign squash = flush && uop_valid && !uop_ready && uop_writes_rd && (uop_rd != '0);

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            uop_valid <= 1'b0;
        end else if (take) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            uop_pc        <= h_pc;
            uop_fu        <= uop_types_pkg::fu_t'(h_fu);
            uop_rd        <= h_rd;
            uop_rs1       <= h_rs1;
            uop_rs2       <= h_rs2;
            uop_imm       <= h_imm;
            uop_funct3    <= h_funct3;
            uop_writes_rd <= h_writes_rd;
        end
    end

    // clears first, then set, so the set wins
    always_ff @(posedge CLK) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            if (squash) begin
                busy[uop_rd] <= 1'b0;
            end
            if (take && h_writes_rd && (h_rd != '0)) begin
                busy[h_rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uop_frontend.sv ====
//////////////////////////////
// fetch -> decoder -> queue -> issue -> execute
// minimum fetch to uop_valid is 3 cycles
// writeback has no ready, always accepted
//////////////////////////////
`default_nettype none

module uop_frontend (
    input  wire                             CLK,
    input  wire                             rst,
    input  wire                             flush,
    // fetch side
    input  wire                             fetch_valid,
    output logic                            fetch_ready,
    input  wire rv32i_types_pkg::word_t     instr,
    input  wire rv32i_types_pkg::word_t     pc,
    // execute side
    output logic                            uop_valid,
    input  wire                             uop_ready,
    output rv32i_types_pkg::word_t          uop_pc,
    output uop_types_pkg::fu_t              uop_fu,
    output rv32i_types_pkg::reg_idx_t       uop_rd,
    output rv32i_types_pkg::reg_idx_t       uop_rs1,
    output rv32i_types_pkg::reg_idx_t       uop_rs2,
    output uop_types_pkg::imm_t             uop_imm,
    output rv32i_types_pkg::funct3_t        uop_funct3,
    output logic                            uop_writes_rd,
    // writeback
    input  wire                             wb_valid,
    input  wire rv32i_types_pkg::reg_idx_t  wb_rd
);

    // decoder to queue
    logic                      dec_valid, dec_ready;
    rv32i_types_pkg::word_t    dec_pc;
    uop_types_pkg::fu_t        dec_fu;
    rv32i_types_pkg::reg_idx_t dec_rd, dec_rs1, dec_rs2;
    logic                      dec_uses_rs1, dec_uses_rs2, dec_writes_rd;
    uop_types_pkg::imm_t       dec_imm;
    rv32i_types_pkg::funct3_t  dec_funct3;
    uop_types_pkg::uop_entry_t dec_entry;

    // queue to issue
    logic                      q_valid, q_ready;
    uop_types_pkg::uop_entry_t q_entry;

    // pack order must match the unpack in uop_issue
    assign dec_entry = {dec_pc, dec_fu, dec_rd, dec_rs1, dec_rs2, dec_uses_rs1,
                        dec_uses_rs2, dec_writes_rd, dec_imm, dec_funct3};

    uop_decoder u_uop_decoder (
        .CLK(CLK), .rst(rst), .flush(flush),
        .fetch_valid(fetch_valid), .instr(instr), .pc(pc), .dec_ready(dec_ready),
        .fetch_ready(fetch_ready), .dec_valid(dec_valid), .dec_pc(dec_pc),
        .dec_fu(dec_fu), .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_uses_rs1(dec_uses_rs1), .dec_uses_rs2(dec_uses_rs2),
        .dec_writes_rd(dec_writes_rd), .dec_imm(dec_imm), .dec_funct3(dec_funct3)
    );

    // fetch_ready already reflects a full queue
    decode_queue u_decode_queue (
        .CLK(CLK), .rst(rst), .flush(flush),
        .in_valid(dec_valid), .in_entry(dec_entry), .out_ready(q_ready),
        .in_ready(dec_ready), .out_valid(q_valid), .out_entry(q_entry),
        .free_slots()
    );

    uop_issue u_uop_issue (
        .CLK(CLK), .rst(rst), .flush(flush),
        .q_valid(q_valid), .q_entry(q_entry), .uop_ready(uop_ready),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .q_ready(q_ready),
        .uop_valid(uop_valid), .uop_pc(uop_pc), .uop_fu(uop_fu), .uop_rd(uop_rd),
        .uop_rs1(uop_rs1), .uop_rs2(uop_rs2), .uop_imm(uop_imm),
        .uop_funct3(uop_funct3), .uop_writes_rd(uop_writes_rd)
    );

endmodule

`default_nettype wire

// ==== tb_uop_frontend.sv ====
//////////////////////////////
// testbench for uop_frontend
// expected micro-ops come from a reference decoder below
// inputs change 1 unit after the rising edge,
// outputs are checked on the falling edge
// every wait loop is bounded
//////////////////////////////
`default_nettype none

module tb_uop_frontend;

    typedef struct packed {
        rv32i_types_pkg::word_t    pc;
        uop_types_pkg::fu_t        fu;
        rv32i_types_pkg::reg_idx_t rd;
        rv32i_types_pkg::reg_idx_t rs1;
        rv32i_types_pkg::reg_idx_t rs2;
        uop_types_pkg::imm_t       imm;
        rv32i_types_pkg::funct3_t  funct3;
        logic                      writes_rd;
    } exp_t;

    logic                      CLK;
    logic                      rst;
    logic                      flush;
    logic                      fetch_valid;
    logic                      fetch_ready;
    rv32i_types_pkg::word_t    instr;
    rv32i_types_pkg::word_t    pc;
    logic                      uop_valid;
    logic                      uop_ready;
    rv32i_types_pkg::word_t    uop_pc;
    uop_types_pkg::fu_t        uop_fu;
    rv32i_types_pkg::reg_idx_t uop_rd;
    rv32i_types_pkg::reg_idx_t uop_rs1;
    rv32i_types_pkg::reg_idx_t uop_rs2;
    uop_types_pkg::imm_t       uop_imm;
    rv32i_types_pkg::funct3_t  uop_funct3;
    logic                      uop_writes_rd;
    logic                      wb_valid;
    rv32i_types_pkg::reg_idx_t wb_rd;

    // expected stream and writebacks still owed
    exp_t                      exp_q[$];
    rv32i_types_pkg::reg_idx_t wb_pend[$];
    exp_t                      head_e;
    rv32i_types_pkg::word_t    next_pc;
    rv32i_types_pkg::word_t    held_pc;
    int                        errors;
    int                        n_recv;
    int                        n_tests;
    int                        n_failed;
    int                        seed;
    // modes, changed only just after a falling edge
    bit                        ready_level;
    bit                        rand_stall;
    bit                        auto_wb;
    bit                        held;

    uop_frontend u_uop_frontend (
        .CLK(CLK), .rst(rst), .flush(flush),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .instr(instr), .pc(pc),
        .uop_valid(uop_valid), .uop_ready(uop_ready), .uop_pc(uop_pc), .uop_fu(uop_fu),
        .uop_rd(uop_rd), .uop_rs1(uop_rs1), .uop_rs2(uop_rs2), .uop_imm(uop_imm),
        .uop_funct3(uop_funct3), .uop_writes_rd(uop_writes_rd),
        .wb_valid(wb_valid), .wb_rd(wb_rd)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // instruction encoders, immediates as plain integers
    function automatic rv32i_types_pkg::word_t i_type(input int imm, input int rs1,
            input int f3, input int rd, input rv32i_types_pkg::opcode_t opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv32i_types_pkg::word_t s_type(input int imm, input int rs2,
            input int rs1, input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv32i_types_pkg::OPC_STORE};
    endfunction

    function automatic rv32i_types_pkg::word_t b_type(input int imm, input int rs2,
            input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv32i_types_pkg::OPC_BRANCH};
    endfunction

    function automatic rv32i_types_pkg::word_t u_type(input int imm, input int rd,
            input rv32i_types_pkg::opcode_t opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic rv32i_types_pkg::word_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv32i_types_pkg::OPC_JAL};
    endfunction

    function automatic rv32i_types_pkg::word_t r_type(input int f7, input int rs2,
            input int rs1, input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv32i_types_pkg::OPC_OP};
    endfunction

    // reference decode, straight from the ISA formats
    function automatic exp_t ref_uop(input rv32i_types_pkg::word_t w,
            input rv32i_types_pkg::word_t p);
        exp_t e;
        e.pc        = p;
        e.rd        = w[11:7];
        e.rs1       = w[19:15];
        e.rs2       = w[24:20];
        e.funct3    = w[14:12];
        e.fu        = uop_types_pkg::FU_ILLEGAL;
        e.imm       = '0;
        e.writes_rd = 1'b0;
        case (w[6:0])
            rv32i_types_pkg::OPC_LUI, rv32i_types_pkg::OPC_AUIPC: begin
                e.fu  = uop_types_pkg::FU_ALU;
                e.imm = {w[31:12], 12'h000};
            end
            rv32i_types_pkg::OPC_JAL: begin
                e.fu  = uop_types_pkg::FU_BRANCH;
                e.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            end
            rv32i_types_pkg::OPC_JALR: begin
                e.fu  = uop_types_pkg::FU_BRANCH;
                e.imm = 32'($signed(w[31:20]));
            end
            rv32i_types_pkg::OPC_BRANCH: begin
                e.fu  = uop_types_pkg::FU_BRANCH;
                e.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            end
            rv32i_types_pkg::OPC_LOAD: begin
                e.fu  = uop_types_pkg::FU_LSU;
                e.imm = 32'($signed(w[31:20]));
            end
            rv32i_types_pkg::OPC_STORE: begin
                e.fu  = uop_types_pkg::FU_LSU;
                e.imm = 32'($signed({w[31:25], w[11:7]}));
            end
            rv32i_types_pkg::OPC_OPIMM: begin
                e.fu  = uop_types_pkg::FU_ALU;
                e.imm = 32'($signed(w[31:20]));
            end
            rv32i_types_pkg::OPC_SYSTEM: begin
                e.fu  = uop_types_pkg::FU_SYS;
                e.imm = 32'($signed(w[31:20]));
            end
            // register-register carries no immediate
            rv32i_types_pkg::OPC_OP: e.fu = uop_types_pkg::FU_ALU;
            default: ;
        endcase
        // writers are everything except branch, store and illegal
        e.writes_rd = !(w[6:0] == rv32i_types_pkg::OPC_BRANCH
                     || w[6:0] == rv32i_types_pkg::OPC_STORE
                     || e.fu == uop_types_pkg::FU_ILLEGAL);
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
            input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // execute side: every transfer against the front of the expected queue
    always @(negedge CLK) begin
        if (!rst) begin
            if (held) begin
                assert (uop_valid && uop_pc == held_pc) else begin
                    errors++;
                    $display("ERROR time %0t issued micro-op changed while stalled", $time);
                end
            end
            held    = uop_valid && !uop_ready && !flush;
            held_pc = uop_pc;
            if (uop_valid && uop_ready) begin
                n_recv++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR time %0t unexpected micro-op at pc %h", $time, uop_pc);
                end else begin
                    head_e = exp_q.pop_front();
                    check_val("uop_pc", head_e.pc, uop_pc);
                    check_val("uop_fu", 32'(head_e.fu), 32'(uop_fu));
                    check_val("uop_rd", 32'(head_e.rd), 32'(uop_rd));
                    check_val("uop_rs1", 32'(head_e.rs1), 32'(uop_rs1));
                    check_val("uop_rs2", 32'(head_e.rs2), 32'(uop_rs2));
                    check_val("uop_imm", head_e.imm, uop_imm);
                    check_val("uop_funct3", 32'(head_e.funct3), 32'(uop_funct3));
                    check_val("uop_writes_rd", 32'(head_e.writes_rd), 32'(uop_writes_rd));
                end
                if (auto_wb && uop_writes_rd && uop_rd != '0) begin
                    wb_pend.push_back(uop_rd);
                end
            end
            // un-issued micro-ops are gone
            if (flush) begin
                exp_q.delete();
            end
        end
    end

    // execute ready and writeback return
    always @(posedge CLK) begin
        #1;
        uop_ready = rand_stall ? (($random(seed) & 3) != 0) : ready_level;
        if (auto_wb) begin
            if (wb_pend.size() > 0) begin
                wb_valid = 1'b1;
                wb_rd    = wb_pend.pop_front();
            end else begin
                wb_valid = 1'b0;
            end
        end
    end

    task automatic set_mode(input bit level, input bit rnd, input bit wb_on);
        @(negedge CLK);
        #1;
        ready_level = level;
        rand_stall  = rnd;
        auto_wb     = wb_on;
        @(posedge CLK);
        #1;
    endtask

    // one cycle with valid high, valid left up for the caller
    task automatic offer(input rv32i_types_pkg::word_t w, output bit taken);
        fetch_valid = 1'b1;
        instr       = w;
        pc          = next_pc;
        @(negedge CLK);
        taken = fetch_ready;
        @(posedge CLK);
        #1;
        if (taken) begin
            exp_q.push_back(ref_uop(w, next_pc));
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic send(input rv32i_types_pkg::word_t w);
        bit taken;
        int waited;
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < 60) begin
            offer(w, taken);
            waited++;
        end
        fetch_valid = 1'b0;
        if (!taken) begin
            errors++;
            $display("ERROR time %0t fetch never accepted instruction %h", $time, w);
        end
    endtask

    task automatic wait_idle(input int limit);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || uop_valid) && waited < limit) begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || uop_valid) begin
            errors++;
            $display("ERROR time %0t %0d micro-ops never reached execute", $time,
                     exp_q.size());
        end
        // let the last writebacks land
        repeat (3) @(posedge CLK);
        #1;
    endtask

    task automatic write_back(input rv32i_types_pkg::reg_idx_t r);
        wb_valid = 1'b1;
        wb_rd    = r;
        @(posedge CLK);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_before);
        n_tests++;
        if (errors != err_before) begin
            n_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    initial begin
        int base;
        int n_acc;
        int err0;
        int waited;
        bit taken;
        rst         = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        uop_ready   = 1'b0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        ready_level = 1'b0;
        rand_stall  = 1'b0;
        auto_wb     = 1'b0;
        held        = 1'b0;
        next_pc     = 32'h0000_1000;
        errors      = 0;
        n_recv      = 0;
        n_tests     = 0;
        n_failed    = 0;
        seed        = 93691;
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;

        // reset state
        err0 = errors;
        @(negedge CLK);
        check_val("uop_valid", 32'd0, 32'(uop_valid));
        check_val("fetch_ready", 32'd1, 32'(fetch_ready));
        finish_test("reset", err0);

        // every opcode class, some negative immediates
        err0 = errors;
        set_mode(1'b1, 1'b0, 1'b1);
        send(u_type(20'hABCDE, 1, rv32i_types_pkg::OPC_LUI));
        send(u_type(20'h80001, 2, rv32i_types_pkg::OPC_AUIPC));
        send(j_type(-2048, 3));
        send(i_type(-4, 3, 0, 4, rv32i_types_pkg::OPC_JALR));
        send(b_type(-16, 2, 1, 1));
        send(i_type(12, 2, 2, 6, rv32i_types_pkg::OPC_LOAD));
        send(s_type(-20, 6, 2, 2));
        send(i_type(-1, 1, 0, 7, rv32i_types_pkg::OPC_OPIMM));
        send(r_type(7'h20, 2, 1, 0, 8));
        send(i_type(12'h300, 0, 2, 9, rv32i_types_pkg::OPC_SYSTEM));
        send(j_type(4094, 10));
        wait_idle(100);
        finish_test("decode", err0);

        // fill with execute stalled: decoder + queue + issue register
        err0 = errors;
        set_mode(1'b0, 1'b0, 1'b1);
        n_acc = 0;
        taken = 1'b1;
        while (taken && n_acc < 16) begin
            offer(i_type(n_acc, 0, 0, n_acc + 1, rv32i_types_pkg::OPC_OPIMM), taken);
            if (taken) begin
                n_acc++;
            end
        end
        check_val("accepted_before_full", 32'(uop_types_pkg::QUEUE_LEN + 2), 32'(n_acc));
        // the refused word stays offered
        set_mode(1'b0, 1'b1, 1'b1);
        send(i_type(n_acc, 0, 0, n_acc + 1, rv32i_types_pkg::OPC_OPIMM));
        for (int i = 0; i < 14; i++) begin
            send(i_type(i, i % 4, 1, 20 + (i % 8), rv32i_types_pkg::OPC_OPIMM));
        end
        wait_idle(300);
        set_mode(1'b1, 1'b0, 1'b1);
        finish_test("backpressure", err0);

        // RAW on x5, then x0 readers
        err0 = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        base = n_recv;
        send(i_type(1, 0, 0, 5, rv32i_types_pkg::OPC_OPIMM));
        send(r_type(0, 0, 5, 0, 6));
        waited = 0;
        while (n_recv < base + 1 && waited < 20) begin
            @(posedge CLK);
            #1;
            waited++;
        end
        repeat (8) @(posedge CLK);
        #1;
        assert (n_recv == base + 1) else begin
            errors++;
            $display("ERROR time %0t reader of x5 issued without its writeback", $time);
        end
        write_back(5'd5);
        wait_idle(20);
        send(i_type(3, 0, 0, 0, rv32i_types_pkg::OPC_OPIMM));
        send(r_type(0, 0, 0, 0, 7));
        wait_idle(20);
        write_back(5'd6);
        write_back(5'd7);
        finish_test("raw_hazard", err0);

        // flush with work pending in every stage
        err0 = errors;
        set_mode(1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            send(i_type(i, 0, 0, 11 + i, rv32i_types_pkg::OPC_OPIMM));
        end
        // last word still in the decoder register
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        repeat (3) @(posedge CLK);
        #1;
        check_val("uop_valid", 32'd0, 32'(uop_valid));
        set_mode(1'b1, 1'b0, 1'b1);
        send(u_type(20'h12345, 1, rv32i_types_pkg::OPC_LUI));
        send(i_type(-8, 1, 4, 2, rv32i_types_pkg::OPC_LOAD));
        send(s_type(36, 2, 1, 0));
        send(b_type(2046, 2, 1, 5));
        // x11 was owed by the squashed micro-op
        send(r_type(0, 0, 11, 0, 12));
        wait_idle(60);
        finish_test("flush", err0);

        // illegal opcode does not mark its rd field busy
        err0 = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        send(i_type(0, 0, 0, 9, 7'b0001011));
        send(r_type(0, 0, 9, 0, 10));
        wait_idle(20);
        write_back(5'd10);
        finish_test("illegal", err0);

        $display("tests %0d, passed %0d, failed %0d, micro-ops checked %0d, errors %0d",
                 n_tests, n_tests - n_failed, n_failed, n_recv, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rv32i_types_pkg.sv
uop_types_pkg.sv
uop_decoder.sv
decode_queue.sv
uop_issue.sv
uop_frontend.sv
tb_uop_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_uop_frontend -f sim.f \
    && ./obj_dir/Vtb_uop_frontend > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: PASS" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
